// ==== rtl/csr_types_pkg.sv ====
package csr_types_pkg;

    // Machine word width of the core
    localparam int XLEN = 32;

    // CSR address field of the SYSTEM instruction
    localparam int CSR_ADDR_W = 12;

    // Data word as read from or written to a CSR
    typedef logic [XLEN-1:0] xlen_t;

    // Address of one CSR
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // Free running counters are twice the word width,
    // split into low and high halves on read
    typedef logic [2*XLEN-1:0] counter_t;

    // Instruction address
    typedef logic [XLEN-1:0] pc_t;

endpackage

// ==== rtl/riscv_csr_pkg.sv ====
package riscv_csr_pkg;

    import csr_types_pkg::*;

    // Operation requested by the SYSTEM instruction in this slot
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Only User and Machine privilege are implemented
    typedef enum logic [1:0] {
        MODE_USER    = 2'b00,
        MODE_MACHINE = 2'b11
    } priv_mode_e;

    // Machine trap setup and handling
    localparam csr_addr_t CSR_ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_ADDR_MIE      = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE   = 12'h342;

    // Read-only counter views
    localparam csr_addr_t CSR_ADDR_CYCLE    = 12'hc00;
    localparam csr_addr_t CSR_ADDR_TIME     = 12'hc01;
    localparam csr_addr_t CSR_ADDR_CYCLEH   = 12'hc80;
    localparam csr_addr_t CSR_ADDR_TIMEH    = 12'hc81;

    // mstatus field positions
    localparam int MSTATUS_MIE_BIT    = 3;
    localparam int MSTATUS_MPIE_BIT   = 7;
    localparam int MSTATUS_MPP_LO_BIT = 11;
    localparam int MSTATUS_MPP_HI_BIT = 12;
    localparam int MSTATUS_MPRV_BIT   = 17;

    // mie field positions
    localparam int MIE_MTIE_BIT = 7;

    // Interrupt flag in bit 31, exception code 7
    localparam xlen_t MCAUSE_MTIMER     = 32'h8000_0007;
    // Environment call from U is 8, from M is 11
    localparam xlen_t MCAUSE_ECALL_BASE = 32'd8;

endpackage

// ==== rtl/csr_op_if.sv ====
`timescale 1ns/1ns

interface csr_op_if
    import csr_types_pkg::*, riscv_csr_pkg::*;
;

    // Command and address of the current slot
    csr_cmd_e  cmd;
    csr_addr_t addr;
    // Operand of the previous slot, used by the write stage
    xlen_t     operand;

    modport dec (
        output cmd,
        output addr,
        output operand
    );

    modport exe (
        input cmd,
        input addr,
        input operand
    );

endinterface

// ==== rtl/csr_trap_if.sv ====
`timescale 1ns/1ns

interface csr_trap_if
    import csr_types_pkg::*, riscv_csr_pkg::*;
;

    // Trap sequencing towards the register file
    logic       take_irq;
    logic       take_ecall;
    logic       take_mret;
    xlen_t      cause;
    pc_t        epc;
    priv_mode_e cur_mode;

    // Architectural state needed by trap control
    xlen_t      mtvec;
    xlen_t      mepc;
    logic       mstatus_mie;
    logic       mstatus_mpie;
    priv_mode_e mstatus_mpp;
    logic       mie_mtie;

    modport ctrl (
        output take_irq,
        output take_ecall,
        output take_mret,
        output cause,
        output epc,
        output cur_mode,
        input  mtvec,
        input  mepc,
        input  mstatus_mie,
        input  mstatus_mpie,
        input  mstatus_mpp,
        input  mie_mtie
    );

    modport regs (
        input  take_irq,
        input  take_ecall,
        input  take_mret,
        input  cause,
        input  epc,
        input  cur_mode,
        output mtvec,
        output mepc,
        output mstatus_mie,
        output mstatus_mpie,
        output mstatus_mpp,
        output mie_mtie
    );

endinterface

// ==== rtl/csr_decode.sv ====
`timescale 1ns/1ns

module csr_decode
    import csr_types_pkg::*, riscv_csr_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     branch_flush,
    input  csr_cmd_e csr_cmd,
    input  xlen_t    op1_data,
    input  xlen_t    imm_i,
    csr_op_if.dec    op
);

    xlen_t operand_q;

    // A flushed slot becomes a no-op on an address that reads zero
    always_comb begin
        if (branch_flush) begin
            op.cmd  = CSR_X;
            op.addr = '1;
        end else begin
            op.cmd  = csr_cmd;
            op.addr = imm_i[CSR_ADDR_W-1:0];
        end
    end

    // Operand waits one cycle for the read value of the same slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operand_q <= '0;
        end else begin
            operand_q <= op1_data;
        end
    end

    assign op.operand = operand_q;

endmodule

// ==== rtl/csr_trap_ctrl.sv ====
`timescale 1ns/1ns

module csr_trap_ctrl
    import csr_types_pkg::*, riscv_csr_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  counter_t  mtime,
    input  counter_t  mtimecmp,
    input  logic      interrupt_ready,
    input  pc_t       fetch_pc,
    csr_op_if.exe     op,
    csr_trap_if.ctrl  trap,
    output csr_cmd_e  csr_cmd_out,
    output xlen_t     trap_vector,
    output logic      may_interrupt
);

    priv_mode_e mode;
    logic       timer_pending;
    logic       irq_enabled;
    logic       take_irq;
    logic       take_ecall;
    logic       take_mret;

    assign timer_pending = mtime >= mtimecmp;

    // Lower privilege is never masked by MIE
    assign irq_enabled   = trap.mie_mtie &&
                           (mode == MODE_USER || trap.mstatus_mie);
    assign may_interrupt = timer_pending && irq_enabled;

    // Interrupt first, then ecall, then mret
    assign take_irq   = may_interrupt && interrupt_ready;
    assign take_ecall = !take_irq && op.cmd == CSR_ECALL;
    assign take_mret  = !take_irq && op.cmd == CSR_MRET;

    assign trap.take_irq   = take_irq;
    assign trap.take_ecall = take_ecall;
    assign trap.take_mret  = take_mret;
    assign trap.cause      = take_irq ? MCAUSE_MTIMER
                                      : MCAUSE_ECALL_BASE + xlen_t'(mode);
    assign trap.epc        = fetch_pc;
    assign trap.cur_mode   = mode;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode        <= MODE_MACHINE;
            csr_cmd_out <= CSR_X;
            trap_vector <= '0;
        end else begin
            // Interrupt looks like an ecall to the pipeline
            csr_cmd_out <= take_irq ? CSR_ECALL : op.cmd;

            if (take_irq || take_ecall) begin
                mode        <= MODE_MACHINE;
                trap_vector <= trap.mtvec;
            end else if (take_mret) begin
                mode        <= trap.mstatus_mpp;
                trap_vector <= trap.mepc;
            end
        end
    end

endmodule

// ==== rtl/csr_regfile.sv ====
`timescale 1ns/1ns

module csr_regfile
    import csr_types_pkg::*, riscv_csr_pkg::*;
#(
    parameter xlen_t RESET_MTVEC = '0
) (
    input  logic      clk,
    input  logic      arst_n,
    input  counter_t  cycle_count,
    input  counter_t  time_count,
    csr_op_if.exe     op,
    csr_trap_if.regs  trap,
    output xlen_t     csr_rdata
);

    // Implemented mstatus and mie fields
    logic       mstatus_mie;
    logic       mstatus_mpie;
    priv_mode_e mstatus_mpp;
    logic       mstatus_mprv;
    logic       mie_mtie;

    xlen_t      mtvec;
    xlen_t      mscratch;
    xlen_t      mepc;
    xlen_t      mcause;

    // Write stage copies of the slot read one cycle earlier
    csr_cmd_e   wr_cmd;
    csr_addr_t  wr_addr;
    logic       wr_en;
    xlen_t      wdata;

    xlen_t      mstatus_value;
    xlen_t      mie_value;
    xlen_t      rd_value;

    always_comb begin
        mstatus_value = '0;
        mstatus_value[MSTATUS_MIE_BIT]  = mstatus_mie;
        mstatus_value[MSTATUS_MPIE_BIT] = mstatus_mpie;
        mstatus_value[MSTATUS_MPP_HI_BIT:MSTATUS_MPP_LO_BIT] = mstatus_mpp;
        mstatus_value[MSTATUS_MPRV_BIT] = mstatus_mprv;

        mie_value = '0;
        mie_value[MIE_MTIE_BIT] = mie_mtie;
    end

    always_comb begin
        case (op.addr)
            CSR_ADDR_MSTATUS:  rd_value = mstatus_value;
            CSR_ADDR_MIE:      rd_value = mie_value;
            CSR_ADDR_MTVEC:    rd_value = mtvec;
            CSR_ADDR_MSCRATCH: rd_value = mscratch;
            CSR_ADDR_MEPC:     rd_value = mepc;
            CSR_ADDR_MCAUSE:   rd_value = mcause;
            CSR_ADDR_CYCLE:    rd_value = cycle_count[XLEN-1:0];
            CSR_ADDR_CYCLEH:   rd_value = cycle_count[2*XLEN-1:XLEN];
            CSR_ADDR_TIME:     rd_value = time_count[XLEN-1:0];
            CSR_ADDR_TIMEH:    rd_value = time_count[2*XLEN-1:XLEN];
            default:           rd_value = '0;
        endcase
    end

    // Read-modify-write on the value registered last cycle
    always_comb begin
        wr_en = 1'b1;
        case (wr_cmd)
            CSR_W:   wdata = op.operand;
            CSR_S:   wdata = csr_rdata | op.operand;
            CSR_C:   wdata = csr_rdata & ~op.operand;
            default: begin
                wr_en = 1'b0;
                wdata = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_rdata    <= '0;
            wr_cmd       <= CSR_X;
            wr_addr      <= '0;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= MODE_MACHINE;
            mstatus_mprv <= 1'b0;
            mie_mtie     <= 1'b0;
            mtvec        <= RESET_MTVEC;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else begin
            csr_rdata <= rd_value;
            wr_cmd    <= op.cmd;
            wr_addr   <= op.addr;

            if (trap.take_irq) begin
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
                mstatus_mpp  <= trap.cur_mode;
                mepc         <= trap.epc;
                mcause       <= trap.cause;
            end else if (trap.take_ecall) begin
                mcause <= trap.cause;
            end else if (trap.take_mret) begin
                mstatus_mie <= mstatus_mpie;
                mstatus_mpp <= MODE_USER;
                if (mstatus_mpp != MODE_MACHINE) begin
                    mstatus_mprv <= 1'b0;
                end
            end

            // Software write last, it overrides a trap on shared fields
            if (wr_en) begin
                case (wr_addr)
                    CSR_ADDR_MSTATUS: begin
                        mstatus_mie  <= wdata[MSTATUS_MIE_BIT];
                        mstatus_mpie <= wdata[MSTATUS_MPIE_BIT];
                        // Only M and U exist, anything else maps to U
                        mstatus_mpp  <= (wdata[MSTATUS_MPP_HI_BIT:MSTATUS_MPP_LO_BIT] == 2'b11)
                                        ? MODE_MACHINE : MODE_USER;
                        mstatus_mprv <= wdata[MSTATUS_MPRV_BIT];
                    end
                    CSR_ADDR_MIE:      mie_mtie <= wdata[MIE_MTIE_BIT];
                    CSR_ADDR_MTVEC:    mtvec    <= wdata;
                    CSR_ADDR_MSCRATCH: mscratch <= wdata;
                    CSR_ADDR_MEPC:     mepc     <= wdata;
                    CSR_ADDR_MCAUSE:   mcause   <= wdata;
                    default: begin
                    end
                endcase
            end
        end
    end

    assign trap.mtvec        = mtvec;
    assign trap.mepc         = mepc;
    assign trap.mstatus_mie  = mstatus_mie;
    assign trap.mstatus_mpie = mstatus_mpie;
    assign trap.mstatus_mpp  = mstatus_mpp;
    assign trap.mie_mtie     = mie_mtie;

endmodule

// ==== rtl/csr_stage.sv ====
`timescale 1ns/1ns

module csr_stage
    import csr_types_pkg::*, riscv_csr_pkg::*;
#(
    parameter xlen_t RESET_MTVEC = '0
) (
    input  logic     clk,
    input  logic     arst_n,

    input  counter_t cycle_count,
    input  counter_t time_count,
    input  counter_t mtime,
    input  counter_t mtimecmp,

    input  logic     branch_flush,
    input  csr_cmd_e csr_cmd,
    input  xlen_t    op1_data,
    input  xlen_t    imm_i,

    // High when the rest of the pipeline holds no live instruction
    input  logic     interrupt_ready,
    input  pc_t      fetch_pc,

    output csr_cmd_e csr_cmd_out,
    output xlen_t    csr_rdata,
    output xlen_t    trap_vector,
    // Early warning so upstream can drain before the trap
    output logic     may_interrupt
);

    csr_op_if   op_bus ();
    csr_trap_if trap_bus ();

    csr_decode u_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .branch_flush (branch_flush),
        .csr_cmd      (csr_cmd),
        .op1_data     (op1_data),
        .imm_i        (imm_i),
        .op           (op_bus.dec)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .interrupt_ready (interrupt_ready),
        .fetch_pc        (fetch_pc),
        .op              (op_bus.exe),
        .trap            (trap_bus.ctrl),
        .csr_cmd_out     (csr_cmd_out),
        .trap_vector     (trap_vector),
        .may_interrupt   (may_interrupt)
    );

    csr_regfile #(
        .RESET_MTVEC (RESET_MTVEC)
    ) u_regfile (
        .clk         (clk),
        .arst_n      (arst_n),
        .cycle_count (cycle_count),
        .time_count  (time_count),
        .op          (op_bus.exe),
        .trap        (trap_bus.regs),
        .csr_rdata   (csr_rdata)
    );

endmodule

// ==== verif/csr_stage_tb.sv ====
`timescale 1ns/1ns

module csr_stage_tb
    import csr_types_pkg::*, riscv_csr_pkg::*;
;

    // One slot of stimulus and the outputs expected after its edge
    typedef struct {
        csr_cmd_e  cmd;
        csr_addr_t addr;
        xlen_t     operand;
        logic      flush;
        logic      irq_ready;
        xlen_t     exp_rdata;
        csr_cmd_e  exp_cmd;
        xlen_t     exp_tvec;
    } row_t;

    logic        clk;
    logic        arst_n;
    counter_t    cycle_count;
    counter_t    time_count;
    counter_t    mtime;
    counter_t    mtimecmp;
    logic        branch_flush;
    csr_cmd_e    csr_cmd;
    xlen_t       op1_data;
    xlen_t       imm_i;
    logic        interrupt_ready;
    pc_t         fetch_pc;
    csr_cmd_e    csr_cmd_out;
    xlen_t       csr_rdata;
    xlen_t       trap_vector;
    logic        may_interrupt;

    row_t        rows[$];
    int          irq_first_row;
    int          errors;
    int          checks;

    xlen_t       v_scratch;
    xlen_t       v_tvec;
    xlen_t       v_set;
    xlen_t       v_clr;
    xlen_t       v_tvec_final;
    xlen_t       v_epc;
    xlen_t       v_junk;

    csr_stage uut (
        .clk             (clk),
        .arst_n          (arst_n),
        .cycle_count     (cycle_count),
        .time_count      (time_count),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .branch_flush    (branch_flush),
        .csr_cmd         (csr_cmd),
        .op1_data        (op1_data),
        .imm_i           (imm_i),
        .interrupt_ready (interrupt_ready),
        .fetch_pc        (fetch_pc),
        .csr_cmd_out     (csr_cmd_out),
        .csr_rdata       (csr_rdata),
        .trap_vector     (trap_vector),
        .may_interrupt   (may_interrupt)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // mstatus as software sees it, built from the field layout
    function automatic xlen_t mstatus_word(input logic mie, input logic mpie,
                                           input logic [1:0] mpp, input logic mprv);
        xlen_t w;
        w = '0;
        w[MSTATUS_MIE_BIT] = mie;
        w[MSTATUS_MPIE_BIT] = mpie;
        w[MSTATUS_MPP_HI_BIT:MSTATUS_MPP_LO_BIT] = mpp;
        w[MSTATUS_MPRV_BIT] = mprv;
        return w;
    endfunction

    task automatic add_row(input csr_cmd_e cmd, input csr_addr_t addr,
                           input xlen_t operand, input logic flush,
                           input logic irq_ready, input xlen_t exp_rdata,
                           input csr_cmd_e exp_cmd, input xlen_t exp_tvec);
        row_t r;
        r.cmd       = cmd;
        r.addr      = addr;
        r.operand   = operand;
        r.flush     = flush;
        r.irq_ready = irq_ready;
        r.exp_rdata = exp_rdata;
        r.exp_cmd   = exp_cmd;
        r.exp_tvec  = exp_tvec;
        rows.push_back(r);
    endtask

    // Idle slot on address 0, which reads zero
    task automatic drive_idle();
        csr_cmd         = CSR_X;
        imm_i           = '0;
        op1_data        = '0;
        branch_flush    = 1'b0;
        interrupt_ready = 1'b0;
    endtask

    task automatic run_rows(input int first, input int last);
        row_t r;
        for (int i = first; i < last; i++) begin
            r               = rows[i];
            csr_cmd         = r.cmd;
            imm_i           = {{20{r.addr[11]}}, r.addr};
            op1_data        = r.operand;
            branch_flush    = r.flush;
            interrupt_ready = r.irq_ready;
            @(negedge clk);
            check_value($sformatf("csr_rdata (row %0d)", i), 64'(csr_rdata),
                        64'(r.exp_rdata));
            check_value($sformatf("csr_cmd_out (row %0d)", i), 64'(csr_cmd_out),
                        64'(r.exp_cmd));
            check_value($sformatf("trap_vector (row %0d)", i), 64'(trap_vector),
                        64'(r.exp_tvec));
        end
        drive_idle();
    endtask

    task automatic wait_for_interrupt(input int limit, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < limit) begin
            @(negedge clk);
            seen = may_interrupt;
            n++;
        end
    endtask

    // W, S, C, counters, flush, ecall and mret, ending in User mode with MTIE set
    task automatic fill_main_rows();
        xlen_t ms_init;
        xlen_t ms_ones;
        xlen_t ms_setup;
        xlen_t ms_ret;
        xlen_t ms_mprv;
        xlen_t ms_kept;
        xlen_t ms_pre;
        ms_init  = mstatus_word(1'b0, 1'b0, 2'b11, 1'b0);
        ms_ones  = mstatus_word(1'b1, 1'b1, 2'b11, 1'b1);
        ms_setup = mstatus_word(1'b0, 1'b1, 2'b00, 1'b1);
        ms_ret   = mstatus_word(1'b1, 1'b1, 2'b00, 1'b0);
        ms_mprv  = mstatus_word(1'b0, 1'b1, 2'b11, 1'b1);
        ms_kept  = mstatus_word(1'b1, 1'b1, 2'b00, 1'b1);
        ms_pre   = mstatus_word(1'b1, 1'b0, 2'b11, 1'b0);
        add_row(CSR_W, CSR_ADDR_MSCRATCH, v_scratch, 1'b0, 1'b0, '0, CSR_W, '0);
        add_row(CSR_W, CSR_ADDR_MTVEC, v_tvec, 1'b0, 1'b0, '0, CSR_W, '0);
        add_row(CSR_X, CSR_ADDR_MSCRATCH, v_junk, 1'b0, 1'b0, v_scratch, CSR_X, '0);
        add_row(CSR_X, CSR_ADDR_MTVEC, v_junk, 1'b0, 1'b0, v_tvec, CSR_X, '0);
        add_row(CSR_S, CSR_ADDR_MTVEC, v_set, 1'b0, 1'b0, v_tvec, CSR_S, '0);
        add_row(CSR_X, CSR_ADDR_MSCRATCH, v_junk, 1'b0, 1'b0, v_scratch, CSR_X, '0);
        add_row(CSR_C, CSR_ADDR_MTVEC, v_clr, 1'b0, 1'b0, v_tvec | v_set, CSR_C, '0);
        add_row(CSR_X, CSR_ADDR_MSCRATCH, v_junk, 1'b0, 1'b0, v_scratch, CSR_X, '0);
        add_row(CSR_X, CSR_ADDR_MTVEC, v_junk, 1'b0, 1'b0, v_tvec_final, CSR_X, '0);
        add_row(CSR_X, CSR_ADDR_CYCLE, v_junk, 1'b0, 1'b0, cycle_count[31:0], CSR_X, '0);
        add_row(CSR_X, CSR_ADDR_CYCLEH, v_junk, 1'b0, 1'b0, cycle_count[63:32], CSR_X, '0);
        add_row(CSR_X, CSR_ADDR_TIME, v_junk, 1'b0, 1'b0, time_count[31:0], CSR_X, '0);
        add_row(CSR_X, CSR_ADDR_TIMEH, v_junk, 1'b0, 1'b0, time_count[63:32], CSR_X, '0);
        add_row(CSR_X, 12'h7c0, v_junk, 1'b0, 1'b0, '0, CSR_X, '0);
        add_row(CSR_W, CSR_ADDR_MSTATUS, '1, 1'b0, 1'b0, ms_init, CSR_W, '0);
        add_row(CSR_X, CSR_ADDR_MSCRATCH, v_junk, 1'b0, 1'b0, v_scratch, CSR_X, '0);
        add_row(CSR_X, CSR_ADDR_MSTATUS, v_junk, 1'b0, 1'b0, ms_ones, CSR_X, '0);
        // Flushed write must not reach mscratch
        add_row(CSR_W, CSR_ADDR_MSCRATCH, v_junk, 1'b1, 1'b0, '0, CSR_X, '0);
        add_row(CSR_X, CSR_ADDR_MSCRATCH, v_junk, 1'b0, 1'b0, v_scratch, CSR_X, '0);
        add_row(CSR_X, CSR_ADDR_MSCRATCH, v_junk, 1'b0, 1'b0, v_scratch, CSR_X, '0);
        // Ecall from Machine mode, cause 11
        add_row(CSR_ECALL, 12'h000, v_junk, 1'b0, 1'b0, '0, CSR_ECALL, v_tvec_final);
        add_row(CSR_X, CSR_ADDR_MCAUSE, v_junk, 1'b0, 1'b0, 32'd11, CSR_X, v_tvec_final);
        add_row(CSR_W, CSR_ADDR_MEPC, v_epc, 1'b0, 1'b0, '0, CSR_W, v_tvec_final);
        add_row(CSR_W, CSR_ADDR_MSTATUS, ms_setup, 1'b0, 1'b0, ms_ones, CSR_W, v_tvec_final);
        add_row(CSR_X, CSR_ADDR_MEPC, v_junk, 1'b0, 1'b0, v_epc, CSR_X, v_tvec_final);
        add_row(CSR_X, CSR_ADDR_MSTATUS, v_junk, 1'b0, 1'b0, ms_setup, CSR_X, v_tvec_final);
        add_row(CSR_MRET, 12'h000, v_junk, 1'b0, 1'b0, '0, CSR_MRET, v_epc);
        add_row(CSR_X, CSR_ADDR_MSTATUS, v_junk, 1'b0, 1'b0, ms_ret, CSR_X, v_epc);
        // Ecall from User mode, cause 8
        add_row(CSR_ECALL, 12'h000, v_junk, 1'b0, 1'b0, '0, CSR_ECALL, v_tvec_final);
        add_row(CSR_X, CSR_ADDR_MCAUSE, v_junk, 1'b0, 1'b0, 32'd8, CSR_X, v_tvec_final);
        add_row(CSR_W, CSR_ADDR_MIE, 32'h80, 1'b0, 1'b0, '0, CSR_W, v_tvec_final);
        add_row(CSR_X, CSR_ADDR_MSCRATCH, v_junk, 1'b0, 1'b0, v_scratch, CSR_X, v_tvec_final);
        add_row(CSR_X, CSR_ADDR_MIE, v_junk, 1'b0, 1'b0, 32'h80, CSR_X, v_tvec_final);
        // Mret to Machine keeps MPRV and still drops MPP to User
        add_row(CSR_W, CSR_ADDR_MSTATUS, ms_mprv, 1'b0, 1'b0, ms_ret, CSR_W, v_tvec_final);
        add_row(CSR_X, CSR_ADDR_MSCRATCH, v_junk, 1'b0, 1'b0, v_scratch, CSR_X, v_tvec_final);
        add_row(CSR_MRET, 12'h000, v_junk, 1'b0, 1'b0, '0, CSR_MRET, v_epc);
        add_row(CSR_X, CSR_ADDR_MSTATUS, v_junk, 1'b0, 1'b0, ms_kept, CSR_X, v_epc);
        add_row(CSR_MRET, 12'h000, v_junk, 1'b0, 1'b0, '0, CSR_MRET, v_epc);
        add_row(CSR_X, CSR_ADDR_MSTATUS, v_junk, 1'b0, 1'b0, ms_ret, CSR_X, v_epc);
        // MIE and MPIE differ and MPP is Machine before the timer trap
        add_row(CSR_W, CSR_ADDR_MSTATUS, ms_pre, 1'b0, 1'b0, ms_ret, CSR_W, v_epc);
        add_row(CSR_X, CSR_ADDR_MSCRATCH, v_junk, 1'b0, 1'b0, v_scratch, CSR_X, v_epc);
        add_row(CSR_X, CSR_ADDR_MSTATUS, v_junk, 1'b0, 1'b0, ms_pre, CSR_X, v_epc);
    endtask

    // Timer trap from User mode with MIE 1, then the saved state
    task automatic fill_irq_rows();
        xlen_t ms_trap;
        ms_trap = mstatus_word(1'b0, 1'b1, 2'b00, 1'b0);
        add_row(CSR_X, 12'h000, v_junk, 1'b0, 1'b1, '0, CSR_ECALL, v_tvec_final);
        add_row(CSR_X, CSR_ADDR_MEPC, v_junk, 1'b0, 1'b0, fetch_pc, CSR_X, v_tvec_final);
        add_row(CSR_X, CSR_ADDR_MCAUSE, v_junk, 1'b0, 1'b0, 32'h8000_0007, CSR_X,
                v_tvec_final);
        add_row(CSR_X, CSR_ADDR_MSTATUS, v_junk, 1'b0, 1'b0, ms_trap, CSR_X, v_tvec_final);
    endtask

    initial begin
        logic seen;
        void'($urandom(9865));
        errors       = 0;
        checks       = 0;
        clk          = 1'b0;
        arst_n       = 1'b0;
        drive_idle();
        cycle_count  = {$urandom(), $urandom()};
        time_count   = {$urandom(), $urandom()};
        mtime        = {1'b0, 31'($urandom()), $urandom()};
        mtimecmp     = mtime;
        fetch_pc     = $urandom();
        v_scratch    = $urandom();
        v_tvec       = $urandom();
        v_set        = $urandom();
        v_clr        = $urandom();
        v_epc        = $urandom();
        v_junk       = $urandom();
        v_tvec_final = (v_tvec | v_set) & ~v_clr;

        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        // Timer is pending here, but MTIE is still clear
        check_value("csr_cmd_out", 64'(csr_cmd_out), 64'(CSR_X));
        check_value("csr_rdata", 64'(csr_rdata), 64'h0);
        check_value("trap_vector", 64'(trap_vector), 64'h0);
        check_value("may_interrupt", 64'(may_interrupt), 64'h0);
        mtimecmp = '1;

        fill_main_rows();
        irq_first_row = rows.size();
        fill_irq_rows();
        run_rows(0, irq_first_row);

        mtimecmp = mtime;
        wait_for_interrupt(20, seen);
        if (!seen) begin
            errors++;
            $display("Timeout: may_interrupt did not rise within 20 cycles");
        end else begin
            run_rows(irq_first_row, rows.size());
            check_value("may_interrupt", 64'(may_interrupt), 64'h0);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== csr_stage.f ====
rtl/csr_types_pkg.sv
rtl/riscv_csr_pkg.sv
rtl/csr_op_if.sv
rtl/csr_trap_if.sv
rtl/csr_decode.sv
rtl/csr_trap_ctrl.sv
rtl/csr_regfile.sv
rtl/csr_stage.sv
verif/csr_stage_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing
TOP      = csr_stage_tb
FILELIST = csr_stage.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
